// File: source/sram_wb_defs.svh
// Wishbone SRAM bridge widths
`ifndef SRAM_WB_DEFS_SVH
`define SRAM_WB_DEFS_SVH

// External asynchronous SRAM organized as 1M x 16
`define SRAM_ADDR_WIDTH 20
`define SRAM_DATA_WIDTH 16

// Classic Wishbone slave port
`define WB_DATA_WIDTH   32
`define WB_ADDR_WIDTH   32
`define WB_SEL_WIDTH    4

// Byte address of the first location in the 2 MiB SRAM window
`define SRAM_BASE_ADDR  32'h8000_0000

`endif

// File: source/sram_wb_pkg.sv
// Wishbone SRAM bridge types
`include "sram_wb_defs.svh"

package sram_wb_pkg;

    // One Wishbone data word, seen whole or as the two SRAM halfwords
    typedef union packed {
        logic [`WB_DATA_WIDTH-1:0]             word;
        logic [1:0][`SRAM_DATA_WIDTH-1:0]      half;
    } wb_word_u;

    // Access phases of one Wishbone cycle
    // PH_LO and PH_HI are the two halfword SRAM accesses
    typedef enum logic [1:0] {
        PH_IDLE = 2'b00,
        PH_LO   = 2'b01,
        PH_HI   = 2'b10,
        PH_ACK  = 2'b11
    } sram_phase_e;

endpackage

// File: source/sram_wb_ctrl.sv
// Wishbone SRAM phase controller
`timescale 1ns/1ps

module sram_wb_ctrl (
    input  logic                        i_clk,
    input  logic                        i_rst,

    input  logic                        i_wb_cyc,
    input  logic                        i_wb_stb,
    input  logic                        i_wb_we,
    input  logic                        i_hit,

    output sram_wb_pkg::sram_phase_e    o_phase,
    output logic                        o_accept,
    output logic                        o_wb_ack,

    output logic                        o_sram_ce_n,
    output logic                        o_sram_oe_n,
    output logic                        o_sram_we_n
);

    sram_wb_pkg::sram_phase_e phase_q;
    sram_wb_pkg::sram_phase_e phase_d;

    logic we_q;
    logic we_d;
    logic sram_active_d;
    logic ce_n_q;
    logic oe_n_q;
    logic we_n_q;

    // ~~~~~~~~~~~~~~~~~~~~
    // Request acceptance

    // Only one access is in flight, so a new request is taken in PH_IDLE only
    assign o_accept = (phase_q == sram_wb_pkg::PH_IDLE) && i_wb_cyc && i_wb_stb;

    // Write flag is latched at accept and held for the whole access
    assign we_d = o_accept ? i_wb_we : we_q;

    // ~~~~~~~~~~~~~~~~~~~~
    // Phase sequencing

    always_comb begin
        phase_d = phase_q;

        case (phase_q)
            sram_wb_pkg::PH_IDLE: begin
                if (o_accept) begin
                    // Misses skip the SRAM and are acknowledged right away
                    phase_d = i_hit ? sram_wb_pkg::PH_LO : sram_wb_pkg::PH_ACK;
                end
            end
            sram_wb_pkg::PH_LO:  phase_d = sram_wb_pkg::PH_HI;
            sram_wb_pkg::PH_HI:  phase_d = sram_wb_pkg::PH_ACK;
            sram_wb_pkg::PH_ACK: phase_d = sram_wb_pkg::PH_IDLE;
            default:             phase_d = sram_wb_pkg::PH_IDLE;
        endcase
    end

    assign sram_active_d = (phase_d == sram_wb_pkg::PH_LO) ||
                           (phase_d == sram_wb_pkg::PH_HI);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            phase_q <= sram_wb_pkg::PH_IDLE;
            we_q    <= 1'b0;
        end else begin
            phase_q <= phase_d;
            we_q    <= we_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // SRAM control pins

    // Registered from the next phase so the strobes change on the same edge
    // as the halfword address and never glitch
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ce_n_q <= 1'b1;
            oe_n_q <= 1'b1;
            we_n_q <= 1'b1;
        end else begin
            ce_n_q <= ~sram_active_d;
            oe_n_q <= ~(sram_active_d && !we_d);
            we_n_q <= ~(sram_active_d && we_d);
        end
    end

    assign o_sram_ce_n = ce_n_q;
    assign o_sram_oe_n = oe_n_q;
    assign o_sram_we_n = we_n_q;

    assign o_phase  = phase_q;
    assign o_wb_ack = (phase_q == sram_wb_pkg::PH_ACK);

endmodule

// File: source/sram_addr_gen.sv
// SRAM window decode and address register
`timescale 1ns/1ps
`include "sram_wb_defs.svh"

module sram_addr_gen (
    input  logic                        i_clk,
    input  logic                        i_rst,

    input  logic [`WB_ADDR_WIDTH-1:0]   i_wb_addr,
    input  logic                        i_accept,
    input  sram_wb_pkg::sram_phase_e    i_phase,

    output logic                        o_hit,
    output logic [`SRAM_ADDR_WIDTH-1:0] o_sram_addr
);

    logic [`WB_ADDR_WIDTH-1:0]   offset;
    logic [`SRAM_ADDR_WIDTH-1:0] addr_q;

    // Byte offset into the window
    // An address below the base wraps to a large offset and misses
    assign offset = i_wb_addr - `SRAM_BASE_ADDR;

    // The window holds 2^(SRAM_ADDR_WIDTH+1) bytes
    assign o_hit = (offset[`WB_ADDR_WIDTH-1:`SRAM_ADDR_WIDTH+1] == '0);

    // Low halfword first, then bit 0 is set for the high halfword
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            addr_q <= '0;
        end else if (i_accept) begin
            addr_q <= {offset[`SRAM_ADDR_WIDTH:2], 1'b0};
        end else if (i_phase == sram_wb_pkg::PH_LO) begin
            addr_q[0] <= 1'b1;
        end
    end

    assign o_sram_addr = addr_q;

endmodule

// File: source/sram_data_path.sv
// SRAM halfword data path
`timescale 1ns/1ps
`include "sram_wb_defs.svh"

module sram_data_path (
    input  logic                        i_clk,
    input  logic                        i_rst,

    input  logic                        i_accept,
    input  sram_wb_pkg::sram_phase_e    i_phase,
    input  logic                        i_wb_we,
    input  logic [`WB_SEL_WIDTH-1:0]    i_wb_sel,
    input  logic [`WB_DATA_WIDTH-1:0]   i_wb_data,

    input  logic [`SRAM_DATA_WIDTH-1:0] i_sram_dq,
    output logic [`SRAM_DATA_WIDTH-1:0] o_sram_dq,
    output logic                        o_sram_ub_n,
    output logic                        o_sram_lb_n,

    output logic [`WB_DATA_WIDTH-1:0]   o_wb_data
);

    localparam int HALF_SEL = `WB_SEL_WIDTH / 2;

    sram_wb_pkg::wb_word_u wdata_q;
    sram_wb_pkg::wb_word_u rdata_q;

    logic                     we_q;
    logic [`WB_SEL_WIDTH-1:0] sel_q;
    logic                     hi_sel;
    logic                     active;
    logic [HALF_SEL-1:0]      half_sel;

    assign hi_sel = (i_phase == sram_wb_pkg::PH_HI);
    assign active = (i_phase == sram_wb_pkg::PH_LO) || hi_sel;

    // ~~~~~~~~~~~~~~~~~~~~
    // Write side

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            we_q         <= 1'b0;
            sel_q        <= '0;
            wdata_q.word <= '0;
        end else if (i_accept) begin
            we_q         <= i_wb_we;
            sel_q        <= i_wb_sel;
            wdata_q.word <= i_wb_data;
        end
    end

    assign half_sel = hi_sel ? sel_q[`WB_SEL_WIDTH-1:HALF_SEL] : sel_q[HALF_SEL-1:0];

    // The SRAM ignores dq while it drives its own outputs
    assign o_sram_dq = wdata_q.half[hi_sel];

    always_comb begin
        if (!active) begin
            o_sram_lb_n = 1'b1;
            o_sram_ub_n = 1'b1;
        end else if (we_q) begin
            o_sram_lb_n = ~half_sel[0];
            o_sram_ub_n = ~half_sel[1];
        end else begin
            // Reads always fetch the full halfword
            o_sram_lb_n = 1'b0;
            o_sram_ub_n = 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Read side

    // Cleared at accept so that a miss returns zero
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rdata_q.word <= '0;
        end else if (i_accept) begin
            rdata_q.word <= '0;
        end else if (active && !we_q) begin
            rdata_q.half[hi_sel] <= i_sram_dq;
        end
    end

    assign o_wb_data = rdata_q.word;

endmodule

// File: source/sram_wb.sv
// Wishbone to SRAM bridge
`timescale 1ns/1ps
`include "sram_wb_defs.svh"

module sram_wb (
    input  logic                        clk,
    input  logic                        i_rst,

    // Wishbone slave
    input  logic                        i_wb_cyc,
    input  logic                        i_wb_stb,
    input  logic                        i_wb_we,
    input  logic [`WB_SEL_WIDTH-1:0]    i_wb_sel,
    input  logic [`WB_ADDR_WIDTH-1:0]   i_wb_addr,
    input  logic [`WB_DATA_WIDTH-1:0]   i_wb_data,
    output logic [`WB_DATA_WIDTH-1:0]   o_wb_data,
    output logic                        o_wb_ack,

    // SRAM pins
    output logic [`SRAM_ADDR_WIDTH-1:0] o_sram_addr,
    output logic [`SRAM_DATA_WIDTH-1:0] o_sram_dq,
    input  logic [`SRAM_DATA_WIDTH-1:0] i_sram_dq,
    output logic                        o_sram_ce_n,
    output logic                        o_sram_we_n,
    output logic                        o_sram_oe_n,
    output logic                        o_sram_ub_n,
    output logic                        o_sram_lb_n
);

    sram_wb_pkg::sram_phase_e phase;
    logic                     accept;
    logic                     hit;

    sram_wb_ctrl sram_wb_ctrl_inst (
        .i_clk(clk),
        .i_rst(i_rst),
        .i_wb_cyc(i_wb_cyc),
        .i_wb_stb(i_wb_stb),
        .i_wb_we(i_wb_we),
        .i_hit(hit),
        .o_phase(phase),
        .o_accept(accept),
        .o_wb_ack(o_wb_ack),
        .o_sram_ce_n(o_sram_ce_n),
        .o_sram_oe_n(o_sram_oe_n),
        .o_sram_we_n(o_sram_we_n)
    );

    sram_addr_gen sram_addr_gen_inst (
        .i_clk(clk),
        .i_rst(i_rst),
        .i_wb_addr(i_wb_addr),
        .i_accept(accept),
        .i_phase(phase),
        .o_hit(hit),
        .o_sram_addr(o_sram_addr)
    );

    sram_data_path sram_data_path_inst (
        .i_clk(clk),
        .i_rst(i_rst),
        .i_accept(accept),
        .i_phase(phase),
        .i_wb_we(i_wb_we),
        .i_wb_sel(i_wb_sel),
        .i_wb_data(i_wb_data),
        .i_sram_dq(i_sram_dq),
        .o_sram_dq(o_sram_dq),
        .o_sram_ub_n(o_sram_ub_n),
        .o_sram_lb_n(o_sram_lb_n),
        .o_wb_data(o_wb_data)
    );

endmodule

// File: test/sram_model.sv
// Behavioral 16-bit SRAM
`timescale 1ns/1ps
`include "sram_wb_defs.svh"

module sram_model (
    input  logic                        i_clk,
    input  logic [`SRAM_ADDR_WIDTH-1:0] i_addr,
    input  logic [`SRAM_DATA_WIDTH-1:0] i_dq,
    output logic [`SRAM_DATA_WIDTH-1:0] o_dq,
    input  logic                        i_ce_n,
    input  logic                        i_we_n,
    input  logic                        i_oe_n,
    input  logic                        i_ub_n,
    input  logic                        i_lb_n
);

    localparam int DEPTH = 1 << `SRAM_ADDR_WIDTH;

    logic [`SRAM_DATA_WIDTH-1:0] mem [DEPTH];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Asynchronous read with each byte lane gated by its strobe
    always_comb begin
        o_dq = '0;
        if (!i_ce_n && !i_oe_n) begin
            if (!i_lb_n) begin
                o_dq[7:0] = mem[i_addr][7:0];
            end
            if (!i_ub_n) begin
                o_dq[15:8] = mem[i_addr][15:8];
            end
        end
    end

    // The write pulse is taken to end at the clock edge
    always @(posedge i_clk) begin
        if (!i_ce_n && !i_we_n) begin
            if (!i_lb_n) begin
                mem[i_addr][7:0] <= i_dq[7:0];
            end
            if (!i_ub_n) begin
                mem[i_addr][15:8] <= i_dq[15:8];
            end
        end
    end

endmodule

// File: test/sram_wb_checker.sv
// Wishbone response checker
`timescale 1ns/1ps
`include "sram_wb_defs.svh"

module sram_wb_checker (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_wb_cyc,
    input  logic                      i_wb_stb,
    input  logic                      i_wb_we,
    input  logic [`WB_SEL_WIDTH-1:0]  i_wb_sel,
    input  logic [`WB_ADDR_WIDTH-1:0] i_wb_addr,
    input  logic [`WB_DATA_WIDTH-1:0] i_wb_data,
    input  logic [`WB_DATA_WIDTH-1:0] i_wb_rdata,
    input  logic                      i_wb_ack,
    input  logic                      i_sram_ce_n,
    input  logic                      i_sram_we_n,
    input  logic                      i_sram_oe_n,
    output int                        o_errors,
    output int                        o_reads,
    output int                        o_writes,
    output int                        o_misses
);

    // Byte memory keyed by offset into the window
    // Bytes never written read as zero
    logic [7:0] mem_bytes [int unsigned];

    logic                      busy;
    int                        edges;
    logic                      req_hit;
    logic                      req_we;
    logic [`WB_SEL_WIDTH-1:0]  req_sel;
    logic [`WB_ADDR_WIDTH-1:0] req_off;
    logic [`WB_DATA_WIDTH-1:0] req_data;
    sram_wb_pkg::wb_word_u     expected;

    initial begin
        o_errors = 0;
        o_reads  = 0;
        o_writes = 0;
        o_misses = 0;
        busy     = 1'b0;
        edges    = 0;
    end

    function automatic sram_wb_pkg::wb_word_u read_model(input logic [31:0] off);
        sram_wb_pkg::wb_word_u w;
        w.word = '0;
        for (int i = 0; i < 4; i++) begin
            if (mem_bytes.exists(off + i)) begin
                w.word[8*i +: 8] = mem_bytes[off + i];
            end
        end
        return w;
    endfunction

    always @(posedge i_clk) begin
        if (i_rst) begin
            busy = 1'b0;
        end else if (!busy) begin
            if (i_wb_ack) begin
                o_errors++;
                $display("FAIL t=%0t o_wb_ack expected 0 got 1 with no access", $time);
            end
            if (!i_sram_ce_n || !i_sram_we_n || !i_sram_oe_n) begin
                o_errors++;
                $display("FAIL t=%0t ce_n/we_n/oe_n expected 111 got %b%b%b while idle",
                         $time, i_sram_ce_n, i_sram_we_n, i_sram_oe_n);
            end
            if (i_wb_cyc && i_wb_stb) begin
                busy     = 1'b1;
                edges    = 0;
                req_off  = i_wb_addr - `SRAM_BASE_ADDR;
                req_hit  = (req_off < 32'h0020_0000);
                req_off[1:0] = 2'b00;
                req_we   = i_wb_we;
                req_sel  = i_wb_sel;
                req_data = i_wb_data;
            end
        end else begin
            edges++;
            if (i_wb_ack) begin
                busy = 1'b0;
                if (edges != (req_hit ? 3 : 1)) begin
                    o_errors++;
                    $display("FAIL t=%0t o_wb_ack latency expected %0d got %0d edges",
                             $time, req_hit ? 3 : 1, edges);
                end
                // A miss expects zero and a hit expects the stored bytes
                expected.word = '0;
                if (req_hit) begin
                    expected = read_model(req_off);
                end
                if (!req_hit) begin
                    o_misses++;
                end else if (req_we) begin
                    o_writes++;
                    for (int i = 0; i < 4; i++) begin
                        if (req_sel[i]) begin
                            mem_bytes[req_off + i] = req_data[8*i +: 8];
                        end
                    end
                end else begin
                    o_reads++;
                end
                if (!req_we && i_wb_rdata !== expected.word) begin
                    o_errors++;
                    $display("FAIL t=%0t o_wb_data expected %08h got %08h (offset %08h)",
                             $time, expected.word, i_wb_rdata, req_off);
                end
            end
        end
    end

endmodule

// File: test/sram_wb_asserts.sv
// Wishbone SRAM bridge protocol assertions
`timescale 1ns/1ps

module sram_wb_asserts (
    input logic i_clk,
    input logic i_rst,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic i_wb_ack,
    input logic i_sram_ce_n,
    input logic i_sram_oe_n,
    input logic i_sram_we_n,
    input logic i_sram_ub_n,
    input logic i_sram_lb_n
);

    int fail_count = 0;

    ack_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_ack |=> !i_wb_ack)
        else begin
            $error("ack held for more than one cycle");
            fail_count++;
        end

    ack_in_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_ack |-> (i_wb_cyc && i_wb_stb))
        else begin
            $error("ack without cyc and stb");
            fail_count++;
        end

    // Reads fetch both byte lanes of the halfword
    read_both_lanes: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_sram_oe_n |-> (!i_sram_ub_n && !i_sram_lb_n))
        else begin
            $error("oe_n low with a byte strobe high");
            fail_count++;
        end

    ce_off_at_ack: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_ack |-> i_sram_ce_n)
        else begin
            $error("ce_n low during ack");
            fail_count++;
        end

endmodule

// File: test/sram_wb_tb.sv
// Wishbone SRAM bridge testbench
`timescale 1ns/1ps
`include "sram_wb_defs.svh"

module sram_wb_tb;

    localparam int NUM_TRANS      = 400;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = NUM_TRANS * 8 + RESET_CYCLES + 100;

    logic                        clk;
    logic                        rst;
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    logic [`WB_SEL_WIDTH-1:0]    wb_sel;
    logic [`WB_ADDR_WIDTH-1:0]   wb_addr;
    logic [`WB_DATA_WIDTH-1:0]   wb_wdata;
    logic [`WB_DATA_WIDTH-1:0]   wb_rdata;
    logic                        wb_ack;
    logic [`SRAM_ADDR_WIDTH-1:0] sram_addr;
    logic [`SRAM_DATA_WIDTH-1:0] sram_wdq;
    logic [`SRAM_DATA_WIDTH-1:0] sram_rdq;
    logic                        ce_n;
    logic                        we_n;
    logic                        oe_n;
    logic                        ub_n;
    logic                        lb_n;
    int                          errors;
    int                          reads;
    int                          writes;
    int                          misses;
    int                          cycles = 0;

    sram_wb UUT (
        .clk(clk), .i_rst(rst),
        .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we), .i_wb_sel(wb_sel),
        .i_wb_addr(wb_addr), .i_wb_data(wb_wdata), .o_wb_data(wb_rdata), .o_wb_ack(wb_ack),
        .o_sram_addr(sram_addr), .o_sram_dq(sram_wdq), .i_sram_dq(sram_rdq),
        .o_sram_ce_n(ce_n), .o_sram_we_n(we_n), .o_sram_oe_n(oe_n),
        .o_sram_ub_n(ub_n), .o_sram_lb_n(lb_n)
    );

    sram_model sram_model_inst (
        .i_clk(clk), .i_addr(sram_addr), .i_dq(sram_wdq), .o_dq(sram_rdq),
        .i_ce_n(ce_n), .i_we_n(we_n), .i_oe_n(oe_n), .i_ub_n(ub_n), .i_lb_n(lb_n)
    );

    sram_wb_checker sram_wb_checker_inst (
        .i_clk(clk), .i_rst(rst), .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
        .i_wb_sel(wb_sel), .i_wb_addr(wb_addr), .i_wb_data(wb_wdata),
        .i_wb_rdata(wb_rdata), .i_wb_ack(wb_ack), .i_sram_ce_n(ce_n),
        .i_sram_we_n(we_n), .i_sram_oe_n(oe_n), .o_errors(errors),
        .o_reads(reads), .o_writes(writes), .o_misses(misses)
    );

    bind sram_wb sram_wb_asserts sram_wb_asserts_inst (
        .i_clk(clk), .i_rst(i_rst), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
        .i_wb_ack(o_wb_ack), .i_sram_ce_n(o_sram_ce_n), .i_sram_oe_n(o_sram_oe_n),
        .i_sram_we_n(o_sram_we_n), .i_sram_ub_n(o_sram_ub_n),
        .i_sram_lb_n(o_sram_lb_n)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the bridge stopped acknowledging", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Wishbone master

    // Most addresses fall in a 64-word slice so that reads find earlier writes
    // Misses alias the slice offsets just above and below the window
    function automatic logic [31:0] pick_address();
        int unsigned kind;
        logic [31:0] off;
        kind = $urandom_range(99, 0);
        off  = $urandom_range(63, 0) << 2;
        if (kind < 80) begin
            return `SRAM_BASE_ADDR + off;
        end else if (kind < 90) begin
            return `SRAM_BASE_ADDR + ($urandom & 32'h001F_FFFC);
        end else if ($urandom_range(1, 0) == 1) begin
            return `SRAM_BASE_ADDR + 32'h0020_0000 + off;
        end
        return off;
    endfunction

    task automatic run_access(input logic [31:0] addr, input logic [31:0] rnd,
                              input logic [31:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_addr  = addr;
        wb_we    = rnd[0];
        wb_sel   = rnd[4:1];
        wb_wdata = data;
        @(posedge clk);
        while (!wb_ack) begin
            @(posedge clk);
        end
        #1;
    endtask

    initial begin
        int total;
        int gap;
        void'($urandom(32'h3d27fa7b));
        clk = 1'b0;
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_sel = '0;
        wb_addr = '0;
        wb_wdata = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) @(posedge clk);
        #1;

        for (int n = 0; n < NUM_TRANS; n++) begin
            run_access(pick_address(), $urandom, $urandom);
            gap = $urandom_range(3, 0);
            if (gap > 0) begin
                wb_cyc = 1'b0;
                wb_stb = 1'b0;
                repeat (gap) @(posedge clk);
                #1;
            end
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        repeat (4) @(posedge clk);

        total = errors + UUT.sram_wb_asserts_inst.fail_count;
        if (reads + writes + misses != NUM_TRANS) begin
            total++;
            $display("Checker saw %0d completed accesses, %0d were issued",
                     reads + writes + misses, NUM_TRANS);
        end
        $display("Done: %0d reads, %0d writes, %0d misses, %0d errors",
                 reads, writes, misses, total);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+source
source/sram_wb_pkg.sv
source/sram_wb_ctrl.sv
source/sram_addr_gen.sv
source/sram_data_path.sv
source/sram_wb.sv
test/sram_model.sv
test/sram_wb_checker.sv
test/sram_wb_asserts.sv
test/sram_wb_tb.sv

// File: Makefile
# Verilator build, run and lint for the Wishbone SRAM bridge
TOP := sram_wb_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): verilog.f $(wildcard source/*.sv source/*.svh test/*.sv)
	verilator --binary --assert --timescale 1ns/1ps -f verilog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/1ps \
		-f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
